/* include/bgpu_settings.svh */
// BGPU build settings
// Bus widths, cluster count, memory depth and thread engine register map

`ifndef BGPU_SETTINGS_SVH
`define BGPU_SETTINGS_SVH

`define BGPU_ADDR_W       12
`define BGPU_DATA_W       32
`define BGPU_CLUSTERS     3
`define BGPU_MEM_WORDS    256
`define BGPU_EXEC_CYCLES  6
`define BGPU_PC_W         16
`define BGPU_TBLOCK_W     8
`define BGPU_TGROUP_W     8

// Thread engine word offsets
`define BGPU_REG_PC       3'd0
`define BGPU_REG_DP       3'd1
`define BGPU_REG_TGROUP   3'd2
`define BGPU_REG_COUNT    3'd3
`define BGPU_REG_START    3'd4
`define BGPU_REG_STATUS   3'd5

`endif

/* hw/bgpu_pkg.sv */
// BGPU shared types
// Debug bus fields, dispatch descriptor and thread engine status word

`default_nettype none
`include "bgpu_settings.svh"

package bgpu_pkg;

    // Select bit sits directly above the byte address
    typedef logic [`BGPU_ADDR_W:0]         dbg_addr_t;
    typedef logic [`BGPU_DATA_W-1:0]       dbg_data_t;
    typedef logic [`BGPU_DATA_W/8-1:0]     dbg_be_t;
    typedef logic [`BGPU_PC_W-1:0]         pc_t;
    typedef logic [`BGPU_TBLOCK_W-1:0]     tblock_idx_t;
    typedef logic [`BGPU_TGROUP_W-1:0]     tgroup_id_t;

    typedef struct packed {
        pc_t         pc;
        dbg_addr_t   dp;
        tblock_idx_t tblock_idx;
        tgroup_id_t  tgroup_id;
    } dispatch_t;

    typedef struct packed {
        logic        busy;
        tblock_idx_t done_count;
    } te_status_t;

endpackage

`default_nettype wire

/* hw/dbg_bus_if.sv */
// Debug bus
// Request/grant with a single-cycle response strobe one cycle after grant

`timescale 1ns/1ps
`default_nettype none

interface dbg_bus_if import bgpu_pkg::*; ();

    // Request channel
    logic      req;
    logic      we;
    dbg_addr_t addr;
    dbg_data_t wdata;
    dbg_be_t   be;

    // Grant and response
    logic      gnt;
    logic      rvalid;
    dbg_data_t rdata;

    modport manager (output req, we, addr, wdata, be, input gnt, rvalid, rdata);

    modport subordinate (input req, we, addr, wdata, be, output gnt, rvalid, rdata);

endinterface

`default_nettype wire

/* hw/dbg_demux.sv */
// Debug bus demux
// Top address bit picks dummy memory or thread engine, response steered back

`timescale 1ns/1ps
`default_nettype none
`include "bgpu_settings.svh"

module dbg_demux import bgpu_pkg::*; (
    input  logic           clk_i,
    input  logic           rst_i,
    dbg_bus_if.subordinate up_bus,
    dbg_bus_if.manager     mem_bus,
    dbg_bus_if.manager     te_bus
);
    logic sel;
    logic sel_q;

    // High half of the address space belongs to the thread engine
    assign sel = up_bus.addr[`BGPU_ADDR_W];

    assign mem_bus.req   = up_bus.req & ~sel;
    assign mem_bus.we    = up_bus.we;
    assign mem_bus.addr  = up_bus.addr;
    assign mem_bus.wdata = up_bus.wdata;
    assign mem_bus.be    = up_bus.be;

    assign te_bus.req   = up_bus.req & sel;
    assign te_bus.we    = up_bus.we;
    assign te_bus.addr  = up_bus.addr;
    assign te_bus.wdata = up_bus.wdata;
    assign te_bus.be    = up_bus.be;

    assign up_bus.gnt = sel ? te_bus.gnt : mem_bus.gnt;

    // Remember the granted target for the response cycle
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            sel_q <= 1'b0;
        end else if (up_bus.req && up_bus.gnt) begin
            sel_q <= sel;
        end
    end

    assign up_bus.rvalid = sel_q ? te_bus.rvalid : mem_bus.rvalid;
    assign up_bus.rdata  = sel_q ? te_bus.rdata : mem_bus.rdata;

    // Each target answers only what it was granted one cycle before
    a_mem_rsp_after_gnt: assert property (@(posedge clk_i) disable iff (rst_i)
        mem_bus.rvalid |-> $past(mem_bus.req && mem_bus.gnt));
    a_te_rsp_after_gnt: assert property (@(posedge clk_i) disable iff (rst_i)
        te_bus.rvalid |-> $past(te_bus.req && te_bus.gnt));

endmodule

`default_nettype wire

/* hw/dummy_mem.sv */
// Dummy memory
// Byte-enabled word store on the debug bus with one-cycle read latency

`timescale 1ns/1ps
`default_nettype none
`include "bgpu_settings.svh"

module dummy_mem import bgpu_pkg::*; (
    input  logic           clk_i,
    dbg_bus_if.subordinate bus
);
    localparam int unsigned IdxW  = $clog2(`BGPU_MEM_WORDS);
    localparam int unsigned Bytes = `BGPU_DATA_W / 8;

    dbg_data_t       mem_q [`BGPU_MEM_WORDS];
    logic [IdxW-1:0] word_idx;
    logic            rvalid_q;
    dbg_data_t       rdata_q;

    assign bus.gnt  = bus.req;
    assign word_idx = bus.addr[IdxW+1:2];

    // Only enabled byte lanes are written
    always_ff @(posedge clk_i) begin
        if (bus.req && bus.we) begin
            for (int b = 0; b < Bytes; b++) begin
                if (bus.be[b]) begin
                    mem_q[word_idx][8*b +: 8] <= bus.wdata[8*b +: 8];
                end
            end
        end
    end

    // Response strobe follows every accepted request
    always_ff @(posedge clk_i) begin
        if (bus.req && !bus.we) begin
            rdata_q <= mem_q[word_idx];
        end
        rvalid_q <= bus.req;
    end

    assign bus.rvalid = rvalid_q;
    assign bus.rdata  = rdata_q;

endmodule

`default_nettype wire

/* hw/thread_engine.sv */
// Thread engine
// Register block, thread-block dispatcher and completion counter

`timescale 1ns/1ps
`default_nettype none
`include "bgpu_settings.svh"

module thread_engine import bgpu_pkg::*; (
    input  logic           clk_i,
    input  logic           rst_i,
    dbg_bus_if.subordinate bus,
    input  logic           warp_free_i,
    output logic           allocate_o,
    output dispatch_t      dispatch_o,
    input  logic           tblock_done_i,
    input  tgroup_id_t     tblock_done_id_i,
    output logic           tblock_done_ready_o
);
    logic [2:0]  reg_idx;
    logic        wr_en;
    logic        rd_en;
    logic        start;
    pc_t         pc_q;
    dbg_addr_t   dp_q;
    tgroup_id_t  tgroup_q;
    tblock_idx_t count_q;
    logic        busy_q;
    tblock_idx_t done_cnt_q;
    tblock_idx_t done_cnt_d;
    tblock_idx_t tblock_idx_q;
    logic        done_hit;
    logic        rvalid_q;
    dbg_data_t   rdata_q;
    te_status_t  status;

    // ###################################################################
    // Register access
    // ###################################################################

    assign bus.gnt = bus.req;
    assign reg_idx = bus.addr[4:2];
    assign wr_en   = bus.req & bus.we;
    assign rd_en   = bus.req & ~bus.we;
    assign start   = wr_en && (reg_idx == `BGPU_REG_START) && !busy_q;

    // Kernel setup is frozen while a run is active
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            pc_q     <= '0;
            dp_q     <= '0;
            tgroup_q <= '0;
            count_q  <= '0;
        end else if (wr_en && !busy_q) begin
            case (reg_idx)
                `BGPU_REG_PC:     pc_q     <= bus.wdata[`BGPU_PC_W-1:0];
                `BGPU_REG_DP:     dp_q     <= bus.wdata[`BGPU_ADDR_W:0];
                `BGPU_REG_TGROUP: tgroup_q <= bus.wdata[`BGPU_TGROUP_W-1:0];
                `BGPU_REG_COUNT:  count_q  <= bus.wdata[`BGPU_TBLOCK_W-1:0];
                default: ;
            endcase
        end
    end

    assign status.busy       = busy_q;
    assign status.done_count = done_cnt_q;

    always_ff @(posedge clk_i) begin
        if (rd_en) begin
            case (reg_idx)
                `BGPU_REG_PC:     rdata_q <= dbg_data_t'(pc_q);
                `BGPU_REG_DP:     rdata_q <= dbg_data_t'(dp_q);
                `BGPU_REG_TGROUP: rdata_q <= dbg_data_t'(tgroup_q);
                `BGPU_REG_COUNT:  rdata_q <= dbg_data_t'(count_q);
                `BGPU_REG_STATUS: rdata_q <= dbg_data_t'(status);
                default:          rdata_q <= '0;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            rvalid_q <= 1'b0;
        end else begin
            rvalid_q <= bus.req;
        end
    end

    assign bus.rvalid = rvalid_q;
    assign bus.rdata  = rdata_q;

    // ###################################################################
    // Dispatch and completion
    // ###################################################################

    assign allocate_o = busy_q && (tblock_idx_q < count_q) && warp_free_i;

    assign dispatch_o.pc         = pc_q;
    assign dispatch_o.dp         = dp_q;
    assign dispatch_o.tblock_idx = tblock_idx_q;
    assign dispatch_o.tgroup_id  = tgroup_q;

    // Completions are always taken, only the running group is counted
    assign tblock_done_ready_o = 1'b1;
    assign done_hit   = tblock_done_i && tblock_done_ready_o && (tblock_done_id_i == tgroup_q);
    assign done_cnt_d = done_cnt_q + tblock_idx_t'(done_hit);

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            busy_q       <= 1'b0;
            done_cnt_q   <= '0;
            tblock_idx_q <= '0;
        end else if (start) begin
            busy_q       <= 1'b1;
            done_cnt_q   <= '0;
            tblock_idx_q <= '0;
        end else if (busy_q) begin
            if (allocate_o) begin
                tblock_idx_q <= tblock_idx_q + 1'b1;
            end
            done_cnt_q <= done_cnt_d;
            // Last block counted ends the run
            if (done_cnt_d == count_q) begin
                busy_q <= 1'b0;
            end
        end
    end

    // Completions never outnumber the blocks handed out in this run
    a_done_within_alloc: assert property (@(posedge clk_i) disable iff (rst_i)
        busy_q |-> (done_cnt_q <= tblock_idx_q));

endmodule

`default_nettype wire

/* hw/compute_cluster.sv */
// Compute cluster stand-in
// One warp slot held for a fixed execution time, then reports its thread group

`timescale 1ns/1ps
`default_nettype none
`include "bgpu_settings.svh"

module compute_cluster import bgpu_pkg::*; (
    input  logic       clk_i,
    input  logic       rst_i,
    output logic       free_o,
    input  logic       allocate_i,
    input  dispatch_t  dispatch_i,
    output logic       done_o,
    output tgroup_id_t done_id_o,
    input  logic       done_ready_i
);
    localparam int unsigned CntW = $clog2(`BGPU_EXEC_CYCLES + 1);

    logic            occupied_q;
    logic            done_q;
    logic [CntW-1:0] cnt_q;
    tgroup_id_t      tgroup_q;

    // Slot lifecycle: allocate, count down, report, release
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            occupied_q <= 1'b0;
            done_q     <= 1'b0;
            cnt_q      <= '0;
        end else if (allocate_i) begin
            occupied_q <= 1'b1;
            cnt_q      <= CntW'(`BGPU_EXEC_CYCLES - 1);
        end else if (done_q) begin
            if (done_ready_i) begin
                occupied_q <= 1'b0;
                done_q     <= 1'b0;
            end
        end else if (occupied_q) begin
            if (cnt_q == '0) begin
                done_q <= 1'b1;
            end else begin
                cnt_q <= cnt_q - 1'b1;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (allocate_i) begin
            tgroup_q <= dispatch_i.tgroup_id;
        end
    end

    assign free_o    = ~occupied_q;
    assign done_o    = done_q;
    assign done_id_o = tgroup_q;

    // Array must only route allocations to a free slot
    a_no_double_alloc: assert property (@(posedge clk_i) disable iff (rst_i)
        allocate_i |-> !occupied_q);

endmodule

`default_nettype wire

/* hw/cluster_array.sv */
// Compute cluster array
// First-free allocation and round-robin arbitration of completion reports

`timescale 1ns/1ps
`default_nettype none
`include "bgpu_settings.svh"

module cluster_array import bgpu_pkg::*; (
    input  logic       clk_i,
    input  logic       rst_i,
    output logic       warp_free_o,
    input  logic       allocate_i,
    input  dispatch_t  dispatch_i,
    output logic       tblock_done_o,
    output tgroup_id_t tblock_done_id_o,
    input  logic       tblock_done_ready_i
);
    localparam int unsigned N    = `BGPU_CLUSTERS;
    localparam int unsigned PtrW = (N > 1) ? $clog2(N) : 1;

    logic [N-1:0]    free;
    logic [N-1:0]    alloc;
    logic [N-1:0]    done;
    logic [N-1:0]    done_ready;
    tgroup_id_t      done_id [N];
    logic            alloc_taken;
    logic            found;
    int unsigned     cand;
    logic [PtrW-1:0] rr_ptr_q;
    logic [PtrW-1:0] winner;

    assign warp_free_o = |free;

    // Lowest-numbered free cluster takes the block
    always_comb begin
        alloc       = '0;
        alloc_taken = 1'b0;
        for (int i = 0; i < N; i++) begin
            if (free[i] && !alloc_taken) begin
                alloc[i]    = allocate_i;
                alloc_taken = 1'b1;
            end
        end
    end

    // ###################################################################
    // Round-robin completion arbiter
    // ###################################################################

    // Search starts at the pointer and wraps around
    always_comb begin
        winner = rr_ptr_q;
        found  = 1'b0;
        cand   = 0;
        for (int off = 0; off < N; off++) begin
            cand = int'(rr_ptr_q) + off;
            if (cand >= N) begin
                cand = cand - N;
            end
            if (!found && done[cand]) begin
                winner = PtrW'(cand);
                found  = 1'b1;
            end
        end
    end

    assign tblock_done_o    = found;
    assign tblock_done_id_o = done_id[winner];

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            rr_ptr_q <= '0;
        end else if (tblock_done_o && tblock_done_ready_i) begin
            rr_ptr_q <= (winner == PtrW'(N - 1)) ? '0 : winner + 1'b1;
        end
    end

    for (genvar i = 0; i < N; i++) begin : gen_clusters
        assign done_ready[i] = tblock_done_ready_i && found && (winner == PtrW'(i));

        compute_cluster i_cluster (
            .clk_i       ( clk_i         ),
            .rst_i       ( rst_i         ),
            .free_o      ( free[i]       ),
            .allocate_i  ( alloc[i]      ),
            .dispatch_i  ( dispatch_i    ),
            .done_o      ( done[i]       ),
            .done_id_o   ( done_id[i]    ),
            .done_ready_i( done_ready[i] )
        );
    end

endmodule

`default_nettype wire

/* hw/bgpu_soc.sv */
// BGPU SoC top level
// Debug bus demux to dummy memory and thread engine, plus the cluster array

`timescale 1ns/1ps
`default_nettype none

module bgpu_soc import bgpu_pkg::*; (
    input  logic      clk_i,
    input  logic      rst_i,
    input  logic      dbg_req_i,
    input  logic      dbg_we_i,
    input  dbg_addr_t dbg_addr_i,
    input  dbg_data_t dbg_wdata_i,
    input  dbg_be_t   dbg_be_i,
    output logic      dbg_gnt_o,
    output logic      dbg_rvalid_o,
    output dbg_data_t dbg_rdata_o
);
    logic       warp_free;
    logic       allocate;
    dispatch_t  dispatch;
    logic       tblock_done;
    tgroup_id_t tblock_done_id;
    logic       tblock_done_ready;

    dbg_bus_if up_bus ();
    dbg_bus_if mem_bus ();
    dbg_bus_if te_bus ();

    // ###################################################################
    // Debug bus
    // ###################################################################

    assign up_bus.req   = dbg_req_i;
    assign up_bus.we    = dbg_we_i;
    assign up_bus.addr  = dbg_addr_i;
    assign up_bus.wdata = dbg_wdata_i;
    assign up_bus.be    = dbg_be_i;

    assign dbg_gnt_o    = up_bus.gnt;
    assign dbg_rvalid_o = up_bus.rvalid;
    assign dbg_rdata_o  = up_bus.rdata;

    dbg_demux i_dbg_demux (
        .clk_i  ( clk_i   ),
        .rst_i  ( rst_i   ),
        .up_bus ( up_bus  ),
        .mem_bus( mem_bus ),
        .te_bus ( te_bus  )
    );

    dummy_mem i_dummy_mem (
        .clk_i( clk_i   ),
        .bus  ( mem_bus )
    );

    // ###################################################################
    // Thread engine and compute clusters
    // ###################################################################

    thread_engine i_thread_engine (
        .clk_i              ( clk_i             ),
        .rst_i              ( rst_i             ),
        .bus                ( te_bus            ),
        .warp_free_i        ( warp_free         ),
        .allocate_o         ( allocate          ),
        .dispatch_o         ( dispatch          ),
        .tblock_done_i      ( tblock_done       ),
        .tblock_done_id_i   ( tblock_done_id    ),
        .tblock_done_ready_o( tblock_done_ready )
    );

    cluster_array i_cluster_array (
        .clk_i              ( clk_i             ),
        .rst_i              ( rst_i             ),
        .warp_free_o        ( warp_free         ),
        .allocate_i         ( allocate          ),
        .dispatch_i         ( dispatch          ),
        .tblock_done_o      ( tblock_done       ),
        .tblock_done_id_o   ( tblock_done_id    ),
        .tblock_done_ready_i( tblock_done_ready )
    );

endmodule

`default_nettype wire

/* sim/tb_clock.sv */
// Testbench clock and reset
// Free-running clock, reset held high for a fixed number of cycles

`timescale 1ns/1ps
`default_nettype none

module tb_clock #(
    parameter int PeriodNs    = 100,
    parameter int ResetCycles = 4
) (
    output logic clk_o,
    output logic rst_o
);
    initial begin
        clk_o = 1'b0;
        forever #(PeriodNs / 2) clk_o = ~clk_o;
    end

    // Release on a falling edge like every other DUT input
    initial begin
        rst_o = 1'b1;
        repeat (ResetCycles) @(posedge clk_o);
        @(negedge clk_o);
        rst_o = 1'b0;
    end

endmodule

`default_nettype wire

/* sim/tb_bgpu_soc.sv */
// BGPU SoC testbench
// Debug bus traffic to the dummy memory and the thread engine, checked against a model

`timescale 1ns/1ps
`default_nettype none
`include "bgpu_settings.svh"

module tb_bgpu_soc import bgpu_pkg::*; ();
    localparam int PeriodNs    = 100;
    localparam int OpCycles    = 50;
    localparam int NumFill     = 8;
    localparam int NumMem      = 30;
    localparam int MaxPolls    = 40;
    localparam int RunBlocks   = 7;
    localparam int DisturbWord = 200;
    // Memory and register traffic plus the status polls of two runs
    localparam int BusOps      = NumFill + 2 * NumMem + 24 + 2 * MaxPolls;
    localparam int KindWrite   = 0;
    localparam int KindRead    = 1;
    localparam int KindCheck   = 2;

    logic        clk;
    logic        rst;
    logic        dbg_req;
    logic        dbg_we;
    dbg_addr_t   dbg_addr;
    dbg_data_t   dbg_wdata;
    dbg_be_t     dbg_be;
    logic        dbg_gnt;
    logic        dbg_rvalid;
    dbg_data_t   dbg_rdata;
    logic [31:0] lcg_state;
    int          rsp_kind;
    dbg_data_t   shadow [`BGPU_MEM_WORDS];
    int          kind_q [$];
    dbg_data_t   exp_q [$];
    string       name_q [$];

    tb_clock #(.PeriodNs(PeriodNs), .ResetCycles(4)) i_clock (.clk_o(clk), .rst_o(rst));

    bgpu_soc uut (
        .clk_i       ( clk        ),
        .rst_i       ( rst        ),
        .dbg_req_i   ( dbg_req    ),
        .dbg_we_i    ( dbg_we     ),
        .dbg_addr_i  ( dbg_addr   ),
        .dbg_wdata_i ( dbg_wdata  ),
        .dbg_be_i    ( dbg_be     ),
        .dbg_gnt_o   ( dbg_gnt    ),
        .dbg_rvalid_o( dbg_rvalid ),
        .dbg_rdata_o ( dbg_rdata  )
    );

    // ######################################################################
    // Reporting and checks
    // ######################################################################

    task automatic fail_now(input string why);
        $display("%s", why);
        $display("TEST FAILED");
        $fatal(1);
    endtask

    task automatic check_data(input string name, input dbg_data_t exp, input dbg_data_t act);
        if (act !== exp) begin
            fail_now($sformatf("ERR %0t %s expected %h actual %h", $time, name, exp, act));
        end
    endtask

    task automatic check_status(input string name, input te_status_t exp,
                                input te_status_t act);
        if (act !== exp) begin
            fail_now($sformatf("ERR %0t %s expected busy=%0b count=%0d actual busy=%0b count=%0d",
                               $time, name, exp.busy, exp.done_count, act.busy,
                               act.done_count));
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            fail_now($sformatf("ERR %0t %s expected %b actual %b", $time, name, exp, act));
        end
    endtask

    // ######################################################################
    // Stimulus source and reference model
    // ######################################################################

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function logic [31:0] rand32();
        lcg_state = lcg_next(lcg_state);
        return lcg_state;
    endfunction

    // Enabled byte lanes take the new data, the others keep the old word
    function automatic dbg_data_t merge_bytes(input dbg_data_t old_w, input dbg_data_t new_w,
                                              input dbg_be_t be);
        dbg_data_t res;
        res = old_w;
        for (int b = 0; b < $bits(dbg_be_t); b++) begin
            if (be[b]) begin
                res[8*b +: 8] = new_w[8*b +: 8];
            end
        end
        return res;
    endfunction

    function automatic dbg_data_t fill_word(input logic [7:0] w);
        return {8'h5a, w, ~w, w ^ 8'h3c};
    endfunction

    function automatic int slot_word(input int s);
        return s * 31 + 3;
    endfunction

    // Registers keep only as many bits as their field is wide
    function automatic dbg_data_t reg_expect(input logic [2:0] idx, input dbg_data_t w);
        case (idx)
            `BGPU_REG_PC:     return dbg_data_t'(pc_t'(w));
            `BGPU_REG_DP:     return dbg_data_t'(dbg_addr_t'(w));
            `BGPU_REG_TGROUP: return dbg_data_t'(tgroup_id_t'(w));
            `BGPU_REG_COUNT:  return dbg_data_t'(tblock_idx_t'(w));
            default:          return '0;
        endcase
    endfunction

    // Every dispatched block carries TGROUP, so all of them are counted
    function automatic te_status_t run_status(input tblock_idx_t count);
        te_status_t st;
        st.busy       = 1'b0;
        st.done_count = count;
        return st;
    endfunction

    function automatic dbg_addr_t te_addr(input logic [2:0] idx);
        return dbg_addr_t'((1 << `BGPU_ADDR_W) | (int'(idx) * 4));
    endfunction

    // ######################################################################
    // Bus access
    // ######################################################################

    task automatic bus_op(input logic we, input dbg_addr_t addr, input dbg_data_t wdata,
                          input dbg_be_t be, input int kind, output dbg_data_t rdata);
        int waited;
        kind_q.push_back(kind);
        @(negedge clk);
        dbg_req   = 1'b1;
        dbg_we    = we;
        dbg_addr  = addr;
        dbg_wdata = wdata;
        dbg_be    = be;
        waited    = 0;
        do begin
            @(posedge clk);
            waited++;
        end while (!dbg_gnt && waited < OpCycles);
        if (!dbg_gnt) begin
            fail_now($sformatf("no grant for address %h within %0d cycles", addr, OpCycles));
        end
        @(negedge clk);
        dbg_req = 1'b0;
        // Response strobe belongs to the cycle right after the grant
        check_flag("dbg_rvalid_o", 1'b1, dbg_rvalid);
        rdata = dbg_rdata;
    endtask

    task automatic mem_write(input int word, input dbg_data_t data, input dbg_be_t be);
        dbg_data_t rsp;
        shadow[word] = merge_bytes(shadow[word], data, be);
        bus_op(1'b1, dbg_addr_t'(word * 4), data, be, KindWrite, rsp);
    endtask

    task automatic mem_check(input int word);
        dbg_data_t rsp;
        exp_q.push_back(shadow[word]);
        name_q.push_back($sformatf("dbg_rdata_o mem[%0d]", word));
        bus_op(1'b0, dbg_addr_t'(word * 4), '0, '0, KindCheck, rsp);
    endtask

    task automatic reg_write(input logic [2:0] idx, input dbg_data_t data);
        dbg_data_t rsp;
        bus_op(1'b1, te_addr(idx), data, 4'hf, KindWrite, rsp);
    endtask

    task automatic reg_check(input logic [2:0] idx, input dbg_data_t exp);
        dbg_data_t rsp;
        exp_q.push_back(exp);
        name_q.push_back($sformatf("dbg_rdata_o reg[%0d]", idx));
        bus_op(1'b0, te_addr(idx), '0, '0, KindCheck, rsp);
    endtask

    task automatic status_read(output te_status_t st);
        dbg_data_t rd;
        bus_op(1'b0, te_addr(`BGPU_REG_STATUS), '0, '0, KindRead, rd);
        st = te_status_t'(rd[$bits(te_status_t)-1:0]);
        check_data("dbg_rdata_o STATUS", dbg_data_t'(st), rd);
    endtask

    // Polls STATUS until busy clears, optionally with a second START once blocks are done
    task automatic finish_run(input tblock_idx_t count, input bit disturb);
        te_status_t  st;
        tblock_idx_t last_count;
        bit          disturbed;
        int          polls;
        polls     = 0;
        disturbed = 1'b0;
        status_read(st);
        check_flag("STATUS busy after START", 1'b1, st.busy);
        last_count = st.done_count;
        while (st.busy && polls < MaxPolls) begin
            // A restart would pull the done count back down
            if (disturb && !disturbed && st.done_count != 0) begin
                reg_write(`BGPU_REG_START, 32'h1);
                mem_write(DisturbWord, rand32(), 4'hf);
                mem_check(DisturbWord);
                disturbed = 1'b1;
            end
            status_read(st);
            if (st.done_count < last_count) begin
                fail_now($sformatf("done count dropped from %0d to %0d during a run",
                                   last_count, st.done_count));
            end
            last_count = st.done_count;
            polls++;
        end
        if (st.busy) begin
            fail_now($sformatf("thread engine still busy after %0d status reads", MaxPolls));
        end
        if (disturb && !disturbed) begin
            fail_now("run ended before a second START could be issued");
        end
        check_status("dbg_rdata_o STATUS", run_status(count), st);
    endtask

    // Every response is matched against the request that caused it
    always @(negedge clk) begin
        if (dbg_rvalid === 1'b1) begin
            if (kind_q.size() == 0) begin
                fail_now("response strobe seen without an outstanding request");
            end else begin
                rsp_kind = kind_q.pop_front();
                if (rsp_kind == KindCheck) begin
                    check_data(name_q.pop_front(), exp_q.pop_front(), dbg_rdata);
                end
            end
        end
    end

    initial begin
        #(BusOps * OpCycles * PeriodNs + 10 * PeriodNs);
        fail_now("watchdog timeout, the test did not finish in time");
    end

    initial begin
        logic [31:0] r;
        dbg_data_t   w;
        logic [2:0]  idx;
        int          words [NumMem];
        te_status_t  st;
        lcg_state = 32'hf74d78a4;
        dbg_req   = 1'b0;
        dbg_we    = 1'b0;
        dbg_addr  = '0;
        dbg_wdata = '0;
        dbg_be    = '0;
        @(negedge rst);

        // Quiet bus after reset, engine idle with nothing counted
        repeat (5) begin
            @(negedge clk);
            check_flag("dbg_gnt_o", 1'b0, dbg_gnt);
            check_flag("dbg_rvalid_o", 1'b0, dbg_rvalid);
        end
        status_read(st);
        check_status("dbg_rdata_o STATUS", '0, st);

        // Known contents first, then random byte-enabled writes over them
        for (int i = 0; i < NumFill; i++) begin
            mem_write(slot_word(i), fill_word(8'(slot_word(i))), 4'hf);
        end
        for (int i = 0; i < NumMem; i++) begin
            r        = rand32();
            words[i] = slot_word(int'(r[31:29]));
            mem_write(words[i], rand32(), dbg_be_t'(r[23:20]));
        end
        for (int i = 0; i < NumMem; i++) begin
            mem_check(words[i]);
        end

        for (int k = 0; k < 4; k++) begin
            idx = `BGPU_REG_PC + 3'(k);
            w   = rand32();
            reg_write(idx, w);
            reg_check(idx, reg_expect(idx, w));
        end

        // More blocks than clusters, then a second run that gets disturbed
        reg_write(`BGPU_REG_COUNT, RunBlocks);
        reg_write(`BGPU_REG_START, 32'h1);
        finish_run(tblock_idx_t'(RunBlocks), 1'b0);
        reg_write(`BGPU_REG_START, 32'h1);
        finish_run(tblock_idx_t'(RunBlocks), 1'b1);

        @(negedge clk);
        if (kind_q.size() != 0) begin
            fail_now("bus responses still outstanding at the end of the run");
        end else begin
            $display("TEST PASSED");
            $finish;
        end
    end

endmodule

`default_nettype wire

/* all.f */
+incdir+include
hw/bgpu_pkg.sv
hw/dbg_bus_if.sv
hw/dbg_demux.sv
hw/dummy_mem.sv
hw/thread_engine.sv
hw/compute_cluster.sv
hw/cluster_array.sv
hw/bgpu_soc.sv
sim/tb_clock.sv
sim/tb_bgpu_soc.sv

/* run.sh */
#!/bin/sh
# Build the BGPU testbench with Verilator and run it
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --timescale 1ns/1ps -Wno-fatal \
    -f all.f --top-module tb_bgpu_soc -Mdir obj_dir -o tb_bgpu_soc
out=$(./obj_dir/tb_bgpu_soc 2>&1) || true
echo "$out"
if echo "$out" | grep -q "^TEST PASSED$"; then
    exit 0
fi
exit 1
